// ==== design/patch_pkg.sv ====
package patch_pkg;

    // Pixel format
    localparam int pixel_width = 8;
    localparam int patch_lanes = 16;                       // One lane per kernel tap
    localparam int patch_bits  = pixel_width * patch_lanes; // 128 bit patch

    typedef logic [pixel_width-1:0] pixel_t;

    // One patch word, seen either as a flat vector or as pixel lanes
    // Lane index is kernel row * 4 + kernel column, lane 0 in the low bits
    typedef union packed {
        logic [patch_bits-1:0]     flat; // Storage and output view
        pixel_t [patch_lanes-1:0]  lane; // Packing view
    } patch_word_t;

endpackage

// ==== design/kernel_pkg.sv ====
package kernel_pkg;

    // Fixed 4x4 kernel
    localparam int kernel_w = 4;
    localparam int kernel_h = 4;

    // Number of kernel positions along one image axis
    // Zero when the kernel does not fit at all
    function automatic int out_dim(
        input int extent,  // Image width or height
        input int stride,  // Step between positions
        input int kext     // Kernel width or height
    );
        if (extent < kext) begin
            return 0;
        end
        return (extent - kext) / stride + 1;
    endfunction

endpackage

// ==== design/image_ram.sv ====
`timescale 1ns/1ps

module image_ram
    import patch_pkg::*;
#(
    parameter int max_img_dim = 16
) (
    input  logic clk,
    input  logic reset,
    // Host write port
    input  logic img_wr_en,
    input  logic [$clog2(max_img_dim * max_img_dim)-1:0] img_wr_addr,
    input  pixel_t img_wr_data,
    // Scanner read port
    input  logic rd_en,
    input  logic [$clog2(max_img_dim * max_img_dim)-1:0] rd_addr,
    output pixel_t rd_data,
    output logic rd_valid
);

    localparam int mem_words = max_img_dim * max_img_dim; // Largest image, row-major
    localparam int addr_bits = $clog2(mem_words);

    pixel_t mem [mem_words];

    logic [addr_bits-1:0] wr_index; // Write address into the array
    logic [addr_bits-1:0] rd_index;

    assign wr_index = img_wr_addr;
    assign rd_index = rd_addr;

    // Host side write
    always_ff @(posedge clk) begin
        if (img_wr_en) begin
            mem[wr_index] <= img_wr_data; // Pixel (r,c) sits at r*width + c
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

    // Valid follows the read request by exactly one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

endmodule

// ==== design/window_scanner.sv ====
`timescale 1ns/1ps

module window_scanner
    import patch_pkg::*;
    import kernel_pkg::*;
#(
    parameter int max_img_dim = 16,
    parameter int stride      = 1
) (
    input  logic clk,
    input  logic reset,
    // Control
    input  logic start,
    input  logic [$clog2(max_img_dim + 1)-1:0] img_w,
    input  logic [$clog2(max_img_dim + 1)-1:0] img_h,
    output logic busy,
    output logic done,
    // Image RAM read side
    output logic rd_en,
    output logic [$clog2(max_img_dim * max_img_dim)-1:0] rd_addr,
    input  pixel_t rd_data,
    input  logic rd_valid,
    // Patch FIFO write side
    output logic fifo_clear,
    output logic patch_wr,
    output patch_word_t patch_data
);

    localparam int dim_bits  = $clog2(max_img_dim + 1);          // Holds max_img_dim itself
    localparam int addr_bits = $clog2(max_img_dim * max_img_dim);
    localparam int max_out   = out_dim(max_img_dim, stride, kernel_w);
    localparam int cnt_bits  = $clog2(max_out * max_out + 1);    // Patch counter width
    localparam int kr_bits   = $clog2(kernel_h);
    localparam int kc_bits   = $clog2(kernel_w);
    localparam int lane_bits = $clog2(patch_lanes);

    typedef enum logic [2:0] {
        st_idle,  // Waiting for start
        st_size,  // Output dimensions being latched
        st_next,  // Decide on next patch or finish
        st_read,  // Issue one pixel read
        st_wait   // Wait for the pixel to come back
    } state_t;

    state_t state;

    // Latched configuration
    logic [dim_bits-1:0] img_w_r;
    logic [dim_bits-1:0] img_h_r;
    logic [dim_bits-1:0] out_w;
    logic [cnt_bits-1:0] total;

    logic [dim_bits-1:0] out_w_c; // Computed from the latched size
    logic [dim_bits-1:0] out_h_c;

    // Position counters
    logic [dim_bits-1:0] out_row;  // Output row of current patch
    logic [dim_bits-1:0] out_col;  // Output column of current patch
    logic [kr_bits-1:0]  kr;       // Kernel row offset
    logic [kc_bits-1:0]  kc;       // Kernel column offset
    logic [cnt_bits-1:0] patch_cnt;

    logic [lane_bits-1:0] lane_idx;
    logic                 last_lane;
    logic                 accept;
    logic [addr_bits-1:0] pix_row; // Absolute pixel row
    logic [addr_bits-1:0] pix_col; // Absolute pixel column

    patch_word_t patch_reg; // Lanes collected so far

    assign out_w_c = dim_bits'(out_dim(int'(img_w_r), stride, kernel_w));
    assign out_h_c = dim_bits'(out_dim(int'(img_h_r), stride, kernel_h));

    assign accept    = (state == st_idle) && start;
    assign lane_idx  = lane_bits'(int'(kr) * kernel_w + int'(kc));
    assign last_lane = (lane_idx == lane_bits'(patch_lanes - 1));

    // Pixel address, row * latched width + column
    assign pix_row = addr_bits'(int'(out_row) * stride + int'(kr));
    assign pix_col = addr_bits'(int'(out_col) * stride + int'(kc));
    assign rd_addr = addr_bits'(pix_row * img_w_r + pix_col);

    assign rd_en      = (state == st_read);
    assign busy       = (state != st_idle);
    assign fifo_clear = accept;                                  // Empty FIFO on a new run
    assign patch_wr   = (state == st_wait) && rd_valid && last_lane;

    // Last pixel goes straight into the pushed word
    always_comb begin
        patch_data = patch_reg;
        patch_data.lane[patch_lanes-1] = rd_data;
    end

    // Control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_idle;
            done      <= 1'b0;
            img_w_r   <= '0;
            img_h_r   <= '0;
            out_w     <= '0;
            total     <= '0;
            out_row   <= '0;
            out_col   <= '0;
            kr        <= '0;
            kc        <= '0;
            patch_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state     <= st_size;
                        done      <= 1'b0;   // Done drops as busy rises
                        img_w_r   <= img_w;
                        img_h_r   <= img_h;
                        out_row   <= '0;
                        out_col   <= '0;
                        kr        <= '0;
                        kc        <= '0;
                        patch_cnt <= '0;
                    end
                end
                st_size: begin
                    out_w <= out_w_c;
                    total <= cnt_bits'(int'(out_w_c) * int'(out_h_c)); // Zero if kernel does not fit
                    state <= st_next;
                end
                st_next: begin
                    if (patch_cnt == total) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end else begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    state <= st_wait;        // Read is out, one cycle latency
                end
                st_wait: begin
                    if (rd_valid) begin
                        // Step through the kernel, row-major
                        if (kc == kc_bits'(kernel_w - 1)) begin
                            kc <= '0;
                            kr <= kr + 1'b1; // Wraps to 0 after last row
                        end else begin
                            kc <= kc + 1'b1;
                        end
                        if (last_lane) begin
                            patch_cnt <= patch_cnt + 1'b1;
                            if (out_col == out_w - 1'b1) begin
                                out_col <= '0;
                                out_row <= out_row + 1'b1;
                            end else begin
                                out_col <= out_col + 1'b1;
                            end
                            state <= st_next;
                        end else begin
                            state <= st_read;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Lane capture
    always_ff @(posedge clk) begin
        if (state == st_wait && rd_valid) begin
            patch_reg.lane[lane_idx] <= rd_data;
        end
    end

endmodule

// ==== design/patch_fifo.sv ====
`timescale 1ns/1ps

module patch_fifo
    import patch_pkg::*;
#(
    parameter int depth = 169
) (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    // Push side
    input  logic wr,
    input  patch_word_t wr_data,
    // Pop side
    input  logic rd,
    output patch_word_t rd_data,
    output logic rd_valid,
    output logic empty
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bits = $clog2(depth + 1);

    logic [patch_bits-1:0] mem [depth]; // Flat patch storage

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;

    logic push;
    logic pop;

    assign push  = wr && !clear;     // Clear wins over a push
    assign pop   = rd && (count != '0); // Pop while empty is dropped
    assign empty = (count == '0);

    // Storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data.flat;
        end
    end

    // Registered read data
    always_ff @(posedge clk) begin
        if (pop) begin
            rd_data.flat <= mem[rd_ptr];
        end
    end

    // Pointers, count and valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= pop;  // One cycle pulse per accepted pop
            if (clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;      // Both or neither
                endcase
            end
        end
    end

endmodule

// ==== design/im2col_top.sv ====
`timescale 1ns/1ps

module im2col_top
    import patch_pkg::*;
    import kernel_pkg::*;
#(
    parameter int max_img_dim = 16,
    parameter int stride      = 1
) (
    input  logic clk,
    input  logic reset,
    // Host image load
    input  logic img_wr_en,
    input  logic [$clog2(max_img_dim * max_img_dim)-1:0] img_wr_addr,
    input  pixel_t img_wr_data,
    // Run control
    input  logic start,
    input  logic [$clog2(max_img_dim + 1)-1:0] img_w,
    input  logic [$clog2(max_img_dim + 1)-1:0] img_h,
    output logic busy,
    output logic done,
    // Patch output
    input  logic patch_rd,
    output logic [patch_bits-1:0] patch_out,
    output logic patch_valid,
    output logic patch_empty
);

    localparam int addr_bits  = $clog2(max_img_dim * max_img_dim);
    localparam int max_out    = out_dim(max_img_dim, stride, kernel_w);
    localparam int fifo_depth = (max_out > 0) ? max_out * max_out : 1; // Every patch of the largest image

    logic rd_en;
    logic [addr_bits-1:0] rd_addr;
    pixel_t rd_data;
    logic rd_valid;
    logic fifo_clear;
    logic patch_wr;
    patch_word_t patch_data;
    patch_word_t fifo_rd_data;

    image_ram #(.max_img_dim(max_img_dim)) image_ram_inst (
        .clk(clk), .reset(reset),
        .img_wr_en(img_wr_en), .img_wr_addr(img_wr_addr), .img_wr_data(img_wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .rd_valid(rd_valid)
    );

    window_scanner #(.max_img_dim(max_img_dim), .stride(stride)) window_scanner_inst (
        .clk(clk), .reset(reset),
        .start(start), .img_w(img_w), .img_h(img_h), .busy(busy), .done(done),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .rd_valid(rd_valid),
        .fifo_clear(fifo_clear), .patch_wr(patch_wr), .patch_data(patch_data)
    );

    patch_fifo #(.depth(fifo_depth)) patch_fifo_inst (
        .clk(clk), .reset(reset), .clear(fifo_clear),
        .wr(patch_wr), .wr_data(patch_data),
        .rd(patch_rd), .rd_data(fifo_rd_data), .rd_valid(patch_valid), .empty(patch_empty)
    );

    assign patch_out = fifo_rd_data.flat; // Output as a flat word

endmodule

// ==== verification/im2col_sva.sv ====
`timescale 1ns/1ps

module im2col_sva (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done,
    input logic patch_rd,
    input logic patch_valid,
    input logic patch_empty,
    input logic patch_wr
);

    int fail_count = 0; // Failed assertions so far

    // Valid only answers a pop that found data
    valid_needs_pop: assert property (@(posedge clk) disable iff (reset)
        patch_valid |-> $past(patch_rd && !patch_empty))
        else begin
            $error("patch_valid without an accepted pop one cycle earlier");
            fail_count++;
        end

    // Accepted pop always answered on the next cycle
    pop_gives_valid: assert property (@(posedge clk) disable iff (reset)
        (patch_rd && !patch_empty) |=> patch_valid)
        else begin
            $error("accepted pop not answered by patch_valid");
            fail_count++;
        end

    busy_done_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(busy && done))
        else begin
            $error("busy and done high together");
            fail_count++;
        end

    // Without a push an empty FIFO stays empty and silent
    empty_holds: assert property (@(posedge clk) disable iff (reset)
        (patch_empty && !patch_wr) |=> (patch_empty && !patch_valid))
        else begin
            $error("FIFO left empty state without a push");
            fail_count++;
        end

endmodule

bind im2col_top im2col_sva im2col_sva_inst (
    .clk(clk), .reset(reset), .busy(busy), .done(done),
    .patch_rd(patch_rd), .patch_valid(patch_valid), .patch_empty(patch_empty),
    .patch_wr(patch_wr)     // Internal push strobe of the top
);

// ==== verification/im2col_tb.sv ====
`timescale 1ns/1ps

module im2col_tb
    import patch_pkg::*, kernel_pkg::*;
();

    localparam int max_dim    = 16;
    localparam int stride     = 1;
    localparam int addr_bits  = $clog2(max_dim * max_dim);
    localparam int dim_bits   = $clog2(max_dim + 1);
    localparam int done_limit = 5000;   // Cycles allowed for one full scan
    localparam int valid_limit = 4;     // Cycles to wait for a pop answer

    logic clk;
    logic reset;
    logic img_wr_en;
    logic [addr_bits-1:0] img_wr_addr;
    pixel_t img_wr_data;
    logic start;
    logic [dim_bits-1:0] img_w;
    logic [dim_bits-1:0] img_h;
    logic busy;
    logic done;
    logic patch_rd;
    logic [patch_bits-1:0] patch_out;
    logic patch_valid;
    logic patch_empty;

    pixel_t img_model [max_dim * max_dim]; // Mirror of the image RAM
    patch_word_t exp_q [$];                // Expected patches, oldest first

    im2col_top #(.max_img_dim(max_dim), .stride(stride)) im2col_top_inst (
        .clk(clk), .reset(reset),
        .img_wr_en(img_wr_en), .img_wr_addr(img_wr_addr), .img_wr_data(img_wr_data),
        .start(start), .img_w(img_w), .img_h(img_h), .busy(busy), .done(done),
        .patch_rd(patch_rd), .patch_out(patch_out), .patch_valid(patch_valid),
        .patch_empty(patch_empty)
    );

    always #20 clk = ~clk; // 40 ns period

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Protocol assertions of the bound checker
    always @(negedge clk) begin
        if (im2col_top_inst.im2col_sva_inst.fail_count != 0) begin
            fail_run("a protocol assertion on the DUT outputs failed");
        end
    end

    task automatic check_value(input string test, input logic [patch_bits-1:0] expected,
                               input logic [patch_bits-1:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s: expected %h, actual %h", test, expected, actual));
        end
    endtask

    // Random pixels, row-major, address r*w + c
    task automatic load_image(input int w, input int h);
        pixel_t pix;
        for (int i = 0; i < w * h; i++) begin
            @(negedge clk);
            pix         = pixel_t'($urandom);
            img_wr_en   = 1'b1;
            img_wr_addr = addr_bits'(i);
            img_wr_data = pix;
            img_model[i] = pix;
        end
        @(negedge clk);
        img_wr_en = 1'b0;
    endtask

    // Patch (pr,pc) lane kr*4+kc holds pixel (pr*stride+kr, pc*stride+kc)
    task automatic build_expected(input int w, input int cols, input int rows);
        patch_word_t p;
        exp_q.delete();
        for (int pr = 0; pr < rows; pr++) begin
            for (int pc = 0; pc < cols; pc++) begin
                for (int kr = 0; kr < kernel_h; kr++) begin
                    for (int kc = 0; kc < kernel_w; kc++) begin
                        p.lane[kr * kernel_w + kc] =
                            img_model[(pr * stride + kr) * w + pc * stride + kc];
                    end
                end
                exp_q.push_back(p);
            end
        end
    endtask

    task automatic start_run(input int w, input int h);
        @(negedge clk);
        start = 1'b1;
        img_w = dim_bits'(w);
        img_h = dim_bits'(h);
        @(negedge clk);
        start = 1'b0;   // Accepted on the edge in between
    endtask

    task automatic wait_done(input string test);
        int cycles;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > done_limit) begin
                fail_run($sformatf("timeout: %s never raised done", test));
            end
        end
    endtask

    // One pop; valid must come exactly one cycle later, or never when empty
    task automatic pop_one(input string test, input bit expect_valid,
                           input patch_word_t expected);
        int cycles;
        cycles = 0;
        @(negedge clk);
        patch_rd = 1'b1;
        do begin
            @(negedge clk);
            patch_rd = 1'b0;
            cycles++;
        end while (!patch_valid && cycles < valid_limit);
        if (expect_valid) begin
            if (!patch_valid) begin
                fail_run($sformatf("timeout: %s pop gave no valid", test));
            end
            check_value({test, " latency"}, 1, cycles);
            check_value(test, expected.flat, patch_out);
        end else begin
            check_value({test, " valid on empty pop"}, 0, patch_valid);
        end
    endtask

    task automatic drain_compare(input string test);
        patch_word_t p;
        while (exp_q.size() > 0) begin
            p = exp_q.pop_front();
            pop_one(test, 1'b1, p);
        end
        check_value({test, " empty after drain"}, 1, patch_empty);
        pop_one({test, " extra pop"}, 1'b0, '0);
    endtask

    task automatic test_reset_state();
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        check_value("reset valid", 0, patch_valid);
        check_value("reset empty", 1, patch_empty);
    endtask

    task automatic test_square();
        load_image(8, 8);
        build_expected(8, 5, 5);        // 25 patches
        start_run(8, 8);
        wait_done("square");
        drain_compare("square");
    endtask

    task automatic test_non_square();
        load_image(10, 6);
        build_expected(10, 7, 3);       // 21 patches, width drives addressing
        start_run(10, 6);
        wait_done("non_square");
        drain_compare("non_square");
    endtask

    task automatic test_small_image();
        load_image(3, 8);
        start_run(3, 8);
        wait_done("small_image");
        check_value("small_image empty", 1, patch_empty);
        pop_one("small_image pop", 1'b0, '0);
    endtask

    task automatic test_pop_while_filling();
        int guard;
        patch_word_t p;
        guard = 0;
        load_image(8, 8);
        build_expected(8, 5, 5);
        start_run(8, 8);
        while (!done) begin
            if (!patch_empty) begin
                if (exp_q.size() == 0) begin
                    fail_run("pop_while_filling produced more patches than expected");
                end
                p = exp_q.pop_front();
                pop_one("pop_while_filling", 1'b1, p);
            end else begin
                @(negedge clk);
            end
            guard++;
            if (guard > done_limit) begin
                fail_run("timeout: pop_while_filling never raised done");
            end
        end
        drain_compare("pop_while_filling"); // Whatever was pushed after the last pop
    endtask

    task automatic test_restart();
        patch_word_t p;
        load_image(8, 8);
        build_expected(8, 5, 5);
        start_run(8, 8);
        wait_done("restart first run");
        for (int i = 0; i < 3; i++) begin
            p = exp_q.pop_front();
            pop_one("restart first run", 1'b1, p);
        end
        // 22 patches left unread, new start must drop them
        load_image(6, 6);
        build_expected(6, 3, 3);
        start_run(6, 6);
        wait_done("restart second run");
        drain_compare("restart second run");
    endtask

    initial begin
        void'($urandom(32'h95699749));
        clk         = 1'b0;
        reset       = 1'b1;
        img_wr_en   = 1'b0;
        img_wr_addr = '0;
        img_wr_data = '0;
        start       = 1'b0;
        img_w       = '0;
        img_h       = '0;
        patch_rd    = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_square();
        test_non_square();
        test_small_image();
        test_pop_while_filling();
        test_restart();

        if (im2col_top_inst.im2col_sva_inst.fail_count != 0) begin
            fail_run("a protocol assertion on the DUT outputs failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
design/patch_pkg.sv
design/kernel_pkg.sv
design/image_ram.sv
design/window_scanner.sv
design/patch_fifo.sv
design/im2col_top.sv
verification/im2col_sva.sv
verification/im2col_tb.sv
